//--- design/qsfp_port_config.svh
//--------------------------------------------------------------------------
// Compile-time constants of the QSFP port glue: widths, address map and
// status timing. Included by every RTL file and by the testbench.
//--------------------------------------------------------------------------

`ifndef QSFP_PORT_CONFIG_SVH
`define QSFP_PORT_CONFIG_SVH

// Cage geometry and bus widths
`define QSFP_NUM_LANES      4
`define QSFP_REG_AW         16
`define QSFP_REG_DW         32
`define QSFP_STREAM_W       64

// Region codes, address bits 13:12
`define QSFP_REGION_IO      2'd0
// Former Ethernet/DMA space, now only an error-answering hole
`define QSFP_REGION_ETH     2'd1

// Read word returned by any unmapped region
`define QSFP_ERR_DATA       32'hBAD0_0000

// Cycles that activity stays up after the last transfer
`define QSFP_ACTIVITY_HOLD  16

// Port number reported in PORT_INFO
`define QSFP_PORTNUM        8'd0

`endif

//--- design/qsfp_port_pkg.sv
//--------------------------------------------------------------------------
// Shared types of the QSFP port: register and stream buses, lane mode
//--------------------------------------------------------------------------

`default_nettype none

`include "qsfp_port_config.svh"

package qsfp_port_pkg;

  // Meaningful vector widths
  typedef logic [`QSFP_REG_AW-1:0] reg_addr_t;
  typedef logic [`QSFP_REG_DW-1:0] reg_data_t;
  typedef logic [1:0]              lane_idx_t;
  typedef logic [1:0]              word_sel_t;
  typedef logic [31:0]             beat_count_t;

  // Run-time lane protocol, XGE and CGE codes kept reserved
  typedef enum logic [1:0] {
    DISABLED = 2'd0,
    AURORA   = 2'd1,
    XGE      = 2'd2,
    CGE      = 2'd3
  } lane_mode_t;

  // Register port request, one strobe per cycle at most
  typedef struct packed {
    logic      wr_req;
    logic      rd_req;
    reg_addr_t addr;
    reg_data_t wr_data;
  } reg_req_t;

  // Request steered to a single lane
  typedef struct packed {
    logic      wr;
    logic      rd;
    word_sel_t word;
    reg_data_t wr_data;
  } lane_req_t;

  typedef struct packed {
    logic      rd_resp;
    reg_data_t rd_data;
  } reg_resp_t;

  // One stream beat, valid and ready travel separately
  typedef struct packed {
    logic [`QSFP_STREAM_W-1:0] tdata;
    logic                      tlast;
  } stream_beat_t;

endpackage

`default_nettype wire

//--- design/qsfp_reg_decode.sv
//--------------------------------------------------------------------------
// Register port front end. Registers a request, steers it to one lane's
// I/O registers and merges the lane read responses with the error word.
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qsfp_port_config.svh"

module qsfp_reg_decode (
  input  wire                                                  bus_clk,
  input  wire                                                  rst_i,
  input  qsfp_port_pkg::reg_req_t                              reg_req_i,
  output qsfp_port_pkg::reg_resp_t                             reg_resp_o,
  output qsfp_port_pkg::lane_req_t [`QSFP_NUM_LANES-1:0]       lane_req_o,
  input  qsfp_port_pkg::reg_resp_t [`QSFP_NUM_LANES-1:0]       lane_resp_i
);

  qsfp_port_pkg::reg_req_t  req_q;
  qsfp_port_pkg::lane_idx_t req_lane;
  qsfp_port_pkg::word_sel_t req_word;
  logic [1:0]               req_region;
  logic                     req_is_io;
  logic                     err_resp_q;

  //------------------------------------------------------------------------
  // Request register
  //------------------------------------------------------------------------

  // Strobes cleared by reset
  always_ff @(posedge bus_clk) begin
    if (rst_i) begin
      req_q.wr_req <= 1'b0;
      req_q.rd_req <= 1'b0;
    end else begin
      req_q.wr_req <= reg_req_i.wr_req;
      req_q.rd_req <= reg_req_i.rd_req;
    end
  end

  // Address and write payload
  always_ff @(posedge bus_clk) begin
    req_q.addr    <= reg_req_i.addr;
    req_q.wr_data <= reg_req_i.wr_data;
  end

  //------------------------------------------------------------------------
  // Address split: lane 15:14, region 13:12, word 3:2
  //------------------------------------------------------------------------
  assign req_lane   = req_q.addr[15:14];
  assign req_region = req_q.addr[13:12];
  assign req_word   = req_q.addr[3:2];

  always_comb begin
    case (req_region)
      `QSFP_REGION_IO:  req_is_io = 1'b1;
      // Ethernet/DMA space no longer backed by logic
      `QSFP_REGION_ETH: req_is_io = 1'b0;
      default:          req_is_io = 1'b0;
    endcase
  end

  // Exactly one lane sees the strobe, and only for region 0
  always_comb begin
    for (int i = 0; i < `QSFP_NUM_LANES; i++) begin
      lane_req_o[i].wr      = req_q.wr_req && req_is_io &&
                              (req_lane == qsfp_port_pkg::lane_idx_t'(i));
      lane_req_o[i].rd      = req_q.rd_req && req_is_io &&
                              (req_lane == qsfp_port_pkg::lane_idx_t'(i));
      lane_req_o[i].word    = req_word;
      lane_req_o[i].wr_data = req_q.wr_data;
    end
  end

  // Error read answered on the same schedule as a lane read
  always_ff @(posedge bus_clk) begin
    if (rst_i) begin
      err_resp_q <= 1'b0;
    end else begin
      err_resp_q <= req_q.rd_req && !req_is_io;
    end
  end

  //------------------------------------------------------------------------
  // Response mux, at most one source active
  //------------------------------------------------------------------------
  always_comb begin
    reg_resp_o.rd_resp = err_resp_q;
    reg_resp_o.rd_data = err_resp_q ? `QSFP_ERR_DATA : '0;
    for (int i = 0; i < `QSFP_NUM_LANES; i++) begin
      if (lane_resp_i[i].rd_resp) begin
        reg_resp_o.rd_resp = 1'b1;
        reg_resp_o.rd_data = lane_resp_i[i].rd_data;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/qsfp_lane_regs.sv
//--------------------------------------------------------------------------
// Per-lane I/O registers: mode, port info and beat counters. One instance
// per lane, fed by the register decoder.
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qsfp_port_config.svh"

module qsfp_lane_regs #(
  parameter int LANE = 0
) (
  input  wire                               bus_clk,
  input  wire                               rst_i,
  input  qsfp_port_pkg::lane_req_t          lane_req_i,
  output qsfp_port_pkg::reg_resp_t          lane_resp_o,
  input  wire                               tx_fire_i,
  input  wire                               rx_fire_i,
  input  wire                               link_i,
  output qsfp_port_pkg::lane_mode_t         mode_o
);

  // Word offsets within region 0
  localparam qsfp_port_pkg::word_sel_t WORD_MODE      = 2'd0;
  localparam qsfp_port_pkg::word_sel_t WORD_PORT_INFO = 2'd1;
  localparam qsfp_port_pkg::word_sel_t WORD_TX_BEATS  = 2'd2;
  localparam qsfp_port_pkg::word_sel_t WORD_RX_BEATS  = 2'd3;

  qsfp_port_pkg::lane_mode_t  mode_q;
  qsfp_port_pkg::beat_count_t tx_beats_q;
  qsfp_port_pkg::beat_count_t rx_beats_q;
  qsfp_port_pkg::reg_data_t   port_info;
  qsfp_port_pkg::reg_data_t   rd_mux;
  qsfp_port_pkg::reg_data_t   rd_data_q;
  logic                       rd_resp_q;

  //------------------------------------------------------------------------
  // Mode register
  //------------------------------------------------------------------------

  // Only AURORA is built, anything else lands as DISABLED
  always_ff @(posedge bus_clk) begin
    if (rst_i) begin
      mode_q <= qsfp_port_pkg::DISABLED;
    end else if (lane_req_i.wr && lane_req_i.word == WORD_MODE) begin
      if (lane_req_i.wr_data[1:0] == qsfp_port_pkg::AURORA) begin
        mode_q <= qsfp_port_pkg::AURORA;
      end else begin
        mode_q <= qsfp_port_pkg::DISABLED;
      end
    end
  end

  assign mode_o = mode_q;

  // Beat counters, free running and wrapping
  always_ff @(posedge bus_clk) begin
    if (rst_i) begin
      tx_beats_q <= '0;
      rx_beats_q <= '0;
    end else begin
      if (tx_fire_i) tx_beats_q <= tx_beats_q + 1'b1;
      if (rx_fire_i) rx_beats_q <= rx_beats_q + 1'b1;
    end
  end

  //------------------------------------------------------------------------
  // Read side
  //------------------------------------------------------------------------

  // Port number 31:24, lane 17:16, link 8, mode 1:0
  assign port_info = {`QSFP_PORTNUM, 6'b0, qsfp_port_pkg::lane_idx_t'(LANE),
                      7'b0, link_i, 6'b0, mode_q};

  always_comb begin
    case (lane_req_i.word)
      WORD_MODE:      rd_mux = {30'b0, mode_q};
      WORD_PORT_INFO: rd_mux = port_info;
      WORD_TX_BEATS:  rd_mux = tx_beats_q;
      WORD_RX_BEATS:  rd_mux = rx_beats_q;
      default:        rd_mux = '0;
    endcase
  end

  // One-cycle registered answer
  always_ff @(posedge bus_clk) begin
    if (rst_i) begin
      rd_resp_q <= 1'b0;
    end else begin
      rd_resp_q <= lane_req_i.rd;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (lane_req_i.rd) rd_data_q <= rd_mux;
  end

  assign lane_resp_o.rd_resp = rd_resp_q;
  assign lane_resp_o.rd_data = rd_data_q;

endmodule

`default_nettype wire

//--- design/qsfp_lane_datapath.sv
//--------------------------------------------------------------------------
// Per-lane stream routing. AURORA passes both streams through, DISABLED
// sinks them; also makes the fire strobes, link and activity status.
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qsfp_port_config.svh"

module qsfp_lane_datapath (
  input  wire                           bus_clk,
  input  wire                           rst_i,
  input  qsfp_port_pkg::lane_mode_t     mode_i,
  // Router to transceiver
  input  qsfp_port_pkg::stream_beat_t   v2e_i,
  input  wire                           v2e_valid_i,
  output logic                          v2e_ready_o,
  output qsfp_port_pkg::stream_beat_t   mgt_tx_o,
  output logic                          mgt_tx_valid_o,
  input  wire                           mgt_tx_ready_i,
  // Transceiver to router
  input  qsfp_port_pkg::stream_beat_t   mgt_rx_i,
  input  wire                           mgt_rx_valid_i,
  output logic                          mgt_rx_ready_o,
  output qsfp_port_pkg::stream_beat_t   e2v_o,
  output logic                          e2v_valid_o,
  input  wire                           e2v_ready_i,
  // Status
  input  wire                           mgt_link_i,
  output logic                          tx_fire_o,
  output logic                          rx_fire_o,
  output logic                          link_up_o,
  output logic                          activity_o
);

  localparam int HOLD_W = $clog2(`QSFP_ACTIVITY_HOLD + 1);

  logic              aurora;
  logic [HOLD_W-1:0] hold_cnt_q;

  assign aurora = (mode_i == qsfp_port_pkg::AURORA);

  //------------------------------------------------------------------------
  // Routing, zero latency in both directions
  //------------------------------------------------------------------------

  // TX: back-pressure straight through, sink everything when disabled
  assign mgt_tx_o       = aurora ? v2e_i : '0;
  assign mgt_tx_valid_o = aurora && v2e_valid_i;
  assign v2e_ready_o    = aurora ? mgt_tx_ready_i : 1'b1;

  // RX: same scheme
  assign e2v_o          = aurora ? mgt_rx_i : '0;
  assign e2v_valid_o    = aurora && mgt_rx_valid_i;
  assign mgt_rx_ready_o = aurora ? e2v_ready_i : 1'b1;

  // Transfers only count in AURORA
  assign tx_fire_o = aurora && v2e_valid_i && mgt_tx_ready_i;
  assign rx_fire_o = aurora && mgt_rx_valid_i && e2v_ready_i;

  assign link_up_o = aurora && mgt_link_i;

  // Activity stretcher, reload on any fire
  always_ff @(posedge bus_clk) begin
    if (rst_i) begin
      hold_cnt_q <= '0;
    end else if (tx_fire_o || rx_fire_o) begin
      hold_cnt_q <= HOLD_W'(`QSFP_ACTIVITY_HOLD);
    end else if (hold_cnt_q != '0) begin
      hold_cnt_q <= hold_cnt_q - 1'b1;
    end
  end

  assign activity_o = (hold_cnt_q != '0);

endmodule

`default_nettype wire

//--- design/qsfp_port.sv
//--------------------------------------------------------------------------
// Top of the QSFP port glue: register decoder plus four lanes of mode
// registers and stream routing, all on bus_clk.
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qsfp_port_config.svh"

module qsfp_port (
  input  wire                                                bus_clk,
  input  wire                                                rst_i,
  // Register port
  input  qsfp_port_pkg::reg_req_t                            reg_req_i,
  output qsfp_port_pkg::reg_resp_t                           reg_resp_o,
  // Router to transceiver
  input  qsfp_port_pkg::stream_beat_t [`QSFP_NUM_LANES-1:0]  v2e_i,
  input  wire                         [`QSFP_NUM_LANES-1:0]  v2e_valid_i,
  output logic                        [`QSFP_NUM_LANES-1:0]  v2e_ready_o,
  output qsfp_port_pkg::stream_beat_t [`QSFP_NUM_LANES-1:0]  mgt_tx_o,
  output logic                        [`QSFP_NUM_LANES-1:0]  mgt_tx_valid_o,
  input  wire                         [`QSFP_NUM_LANES-1:0]  mgt_tx_ready_i,
  // Transceiver to router
  input  qsfp_port_pkg::stream_beat_t [`QSFP_NUM_LANES-1:0]  mgt_rx_i,
  input  wire                         [`QSFP_NUM_LANES-1:0]  mgt_rx_valid_i,
  output logic                        [`QSFP_NUM_LANES-1:0]  mgt_rx_ready_o,
  output qsfp_port_pkg::stream_beat_t [`QSFP_NUM_LANES-1:0]  e2v_o,
  output logic                        [`QSFP_NUM_LANES-1:0]  e2v_valid_o,
  input  wire                         [`QSFP_NUM_LANES-1:0]  e2v_ready_i,
  // Status
  input  wire                         [`QSFP_NUM_LANES-1:0]  mgt_link_i,
  output logic                        [`QSFP_NUM_LANES-1:0]  link_up_o,
  output logic                        [`QSFP_NUM_LANES-1:0]  activity_o
);

  qsfp_port_pkg::lane_req_t  [`QSFP_NUM_LANES-1:0] lane_req;
  qsfp_port_pkg::reg_resp_t  [`QSFP_NUM_LANES-1:0] lane_resp;
  qsfp_port_pkg::lane_mode_t [`QSFP_NUM_LANES-1:0] lane_mode;
  logic                      [`QSFP_NUM_LANES-1:0] tx_fire;
  logic                      [`QSFP_NUM_LANES-1:0] rx_fire;

  // Single register front end for all lanes
  qsfp_reg_decode u_reg_decode (
    .bus_clk     (bus_clk),
    .rst_i       (rst_i),
    .reg_req_i   (reg_req_i),
    .reg_resp_o  (reg_resp_o),
    .lane_req_o  (lane_req),
    .lane_resp_i (lane_resp)
  );

  //------------------------------------------------------------------------
  // Lanes
  //------------------------------------------------------------------------
  for (genvar lane = 0; lane < `QSFP_NUM_LANES; lane++) begin : g_lane

    qsfp_lane_regs #(
      .LANE (lane)
    ) u_lane_regs (
      .bus_clk     (bus_clk),
      .rst_i       (rst_i),
      .lane_req_i  (lane_req[lane]),
      .lane_resp_o (lane_resp[lane]),
      .tx_fire_i   (tx_fire[lane]),
      .rx_fire_i   (rx_fire[lane]),
      .link_i      (mgt_link_i[lane]),
      .mode_o      (lane_mode[lane])
    );

    qsfp_lane_datapath u_lane_datapath (
      .bus_clk        (bus_clk),
      .rst_i          (rst_i),
      .mode_i         (lane_mode[lane]),
      .v2e_i          (v2e_i[lane]),
      .v2e_valid_i    (v2e_valid_i[lane]),
      .v2e_ready_o    (v2e_ready_o[lane]),
      .mgt_tx_o       (mgt_tx_o[lane]),
      .mgt_tx_valid_o (mgt_tx_valid_o[lane]),
      .mgt_tx_ready_i (mgt_tx_ready_i[lane]),
      .mgt_rx_i       (mgt_rx_i[lane]),
      .mgt_rx_valid_i (mgt_rx_valid_i[lane]),
      .mgt_rx_ready_o (mgt_rx_ready_o[lane]),
      .e2v_o          (e2v_o[lane]),
      .e2v_valid_o    (e2v_valid_o[lane]),
      .e2v_ready_i    (e2v_ready_i[lane]),
      .mgt_link_i     (mgt_link_i[lane]),
      .tx_fire_o      (tx_fire[lane]),
      .rx_fire_o      (rx_fire[lane]),
      .link_up_o      (link_up_o[lane]),
      .activity_o     (activity_o[lane])
    );

  end : g_lane

endmodule

`default_nettype wire

//--- verif/qsfp_port_assertions.sv
//--------------------------------------------------------------------------
// Protocol checks for the QSFP port, bound into the top level
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qsfp_port_config.svh"

module qsfp_port_assertions (
  input wire                                              bus_clk,
  input wire                                              rst_i,
  input qsfp_port_pkg::reg_req_t                          reg_req_i,
  input qsfp_port_pkg::reg_resp_t                         reg_resp_i,
  input qsfp_port_pkg::lane_mode_t [`QSFP_NUM_LANES-1:0]  lane_mode_i,
  input wire                       [`QSFP_NUM_LANES-1:0]  tx_valid_i,
  input wire                       [`QSFP_NUM_LANES-1:0]  rx_valid_i,
  input wire                       [`QSFP_NUM_LANES-1:0]  link_i,
  input wire                       [`QSFP_NUM_LANES-1:0]  link_up_i
);

  // Failure count, read by the testbench at the end of the run
  int                          assert_errors = 0;
  logic [`QSFP_NUM_LANES-1:0]  aurora_lanes;

  always_comb begin
    for (int i = 0; i < `QSFP_NUM_LANES; i++) begin
      aurora_lanes[i] = (lane_mode_i[i] == qsfp_port_pkg::AURORA);
    end
  end

  // Disabled lanes never present a beat downstream
  a_no_valid_when_disabled: assert property (@(posedge bus_clk) disable iff (rst_i)
      ((tx_valid_i | rx_valid_i) & ~aurora_lanes) == '0)
    else begin
      $error("stream valid high on a disabled lane");
      assert_errors++;
    end

  // Read response exactly two cycles after the read strobe, both ways
  a_read_latency: assert property (@(posedge bus_clk) disable iff (rst_i)
      reg_resp_i.rd_resp == $past(reg_req_i.rd_req, 2))
    else begin
      $error("read response not two cycles after the read request");
      assert_errors++;
    end

  // Link up needs the transceiver link
  a_link_gated: assert property (@(posedge bus_clk) disable iff (rst_i)
      (link_up_i & ~link_i) == '0)
    else begin
      $error("link up reported without transceiver link");
      assert_errors++;
    end

endmodule

bind qsfp_port qsfp_port_assertions u_assertions (
  .bus_clk     (bus_clk),
  .rst_i       (rst_i),
  .reg_req_i   (reg_req_i),
  .reg_resp_i  (reg_resp_o),
  .lane_mode_i (lane_mode),
  .tx_valid_i  (mgt_tx_valid_o),
  .rx_valid_i  (e2v_valid_o),
  .link_i      (mgt_link_i),
  .link_up_i   (link_up_o)
);

`default_nettype wire

//--- verif/qsfp_port_tb.sv
//--------------------------------------------------------------------------
// Testbench of the QSFP port. Random register and stream traffic from a
// fixed seed, checked against a per-lane model of modes and counters.
//--------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "qsfp_port_config.svh"

module qsfp_port_tb;

  localparam int LANES      = `QSFP_NUM_LANES;
  localparam int RD_TIMEOUT = 20;

  logic                                    bus_clk = 1'b0;
  logic                                    rst_i;
  qsfp_port_pkg::reg_req_t                 reg_req;
  qsfp_port_pkg::reg_resp_t                reg_resp;
  qsfp_port_pkg::stream_beat_t [LANES-1:0] v2e;
  logic                        [LANES-1:0] v2e_valid;
  logic                        [LANES-1:0] v2e_ready;
  qsfp_port_pkg::stream_beat_t [LANES-1:0] mgt_tx;
  logic                        [LANES-1:0] mgt_tx_valid;
  logic                        [LANES-1:0] mgt_tx_ready;
  qsfp_port_pkg::stream_beat_t [LANES-1:0] mgt_rx;
  logic                        [LANES-1:0] mgt_rx_valid;
  logic                        [LANES-1:0] mgt_rx_ready;
  qsfp_port_pkg::stream_beat_t [LANES-1:0] e2v;
  logic                        [LANES-1:0] e2v_valid;
  logic                        [LANES-1:0] e2v_ready;
  logic                        [LANES-1:0] mgt_link;
  logic                        [LANES-1:0] link_up;
  logic                        [LANES-1:0] activity;

  // Lane model
  qsfp_port_pkg::lane_mode_t   mode_m     [LANES];
  qsfp_port_pkg::beat_count_t  tx_beats_m [LANES];
  qsfp_port_pkg::beat_count_t  rx_beats_m [LANES];
  int                          act_hold_m [LANES];

  int seed           = 15;
  int value_errors   = 0;
  int timeout_errors = 0;

  qsfp_port u_dut (
    .bus_clk        (bus_clk),
    .rst_i          (rst_i),
    .reg_req_i      (reg_req),
    .reg_resp_o     (reg_resp),
    .v2e_i          (v2e),
    .v2e_valid_i    (v2e_valid),
    .v2e_ready_o    (v2e_ready),
    .mgt_tx_o       (mgt_tx),
    .mgt_tx_valid_o (mgt_tx_valid),
    .mgt_tx_ready_i (mgt_tx_ready),
    .mgt_rx_i       (mgt_rx),
    .mgt_rx_valid_i (mgt_rx_valid),
    .mgt_rx_ready_o (mgt_rx_ready),
    .e2v_o          (e2v),
    .e2v_valid_o    (e2v_valid),
    .e2v_ready_i    (e2v_ready),
    .mgt_link_i     (mgt_link),
    .link_up_o      (link_up),
    .activity_o     (activity)
  );

  always #5 bus_clk = ~bus_clk;

  // Counters and activity hold advance on the DUT's edge
  always @(posedge bus_clk) begin
    logic tx_fire;
    logic rx_fire;
    for (int i = 0; i < LANES; i++) begin
      tx_fire = (mode_m[i] == qsfp_port_pkg::AURORA) && v2e_valid[i] && mgt_tx_ready[i];
      rx_fire = (mode_m[i] == qsfp_port_pkg::AURORA) && mgt_rx_valid[i] && e2v_ready[i];
      if (rst_i) begin
        tx_beats_m[i] = '0;
        rx_beats_m[i] = '0;
        act_hold_m[i] = 0;
      end else begin
        if (tx_fire) tx_beats_m[i] = tx_beats_m[i] + 1;
        if (rx_fire) rx_beats_m[i] = rx_beats_m[i] + 1;
        if (tx_fire || rx_fire) begin
          act_hold_m[i] = `QSFP_ACTIVITY_HOLD;
        end else if (act_hold_m[i] > 0) begin
          act_hold_m[i] = act_hold_m[i] - 1;
        end
      end
    end
  end

  //------------------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------------------
  task automatic check_equal(input string test, input logic [64:0] expected,
                             input logic [64:0] actual);
    assert (actual === expected) else begin
      $display("FAILED %s: expected %0h, actual %0h", test, expected, actual);
      value_errors++;
    end
  endtask

  function automatic qsfp_port_pkg::reg_addr_t make_addr(input int lane, input int region,
                                                         input int word);
    make_addr        = '0;
    make_addr[15:14] = 2'(lane);
    make_addr[13:12] = 2'(region);
    make_addr[3:2]   = 2'(word);
  endfunction

  // Port number 31:24, lane 17:16, link 8, mode 1:0
  function automatic qsfp_port_pkg::reg_data_t port_info_exp(input int lane);
    port_info_exp        = '0;
    port_info_exp[31:24] = `QSFP_PORTNUM;
    port_info_exp[17:16] = 2'(lane);
    port_info_exp[8]     = mgt_link[lane];
    port_info_exp[1:0]   = mode_m[lane];
  endfunction

  // Starts and ends just after a falling edge
  task automatic reg_write(input qsfp_port_pkg::reg_addr_t addr,
                           input qsfp_port_pkg::reg_data_t data);
    reg_req.wr_req  = 1'b1;
    reg_req.addr    = addr;
    reg_req.wr_data = data;
    @(negedge bus_clk);
    reg_req.wr_req = 1'b0;
    @(negedge bus_clk);
    // Only MODE in region 0 is writable, reserved codes fold to DISABLED
    if (addr[13:12] == `QSFP_REGION_IO && addr[3:2] == 2'd0) begin
      mode_m[addr[15:14]] = (data[1:0] == 2'd1) ? qsfp_port_pkg::AURORA
                                                : qsfp_port_pkg::DISABLED;
    end
  endtask

  task automatic reg_read(input qsfp_port_pkg::reg_addr_t addr,
                          output qsfp_port_pkg::reg_data_t data);
    int waited;
    waited         = 0;
    reg_req.rd_req = 1'b1;
    reg_req.addr   = addr;
    do begin
      @(negedge bus_clk);
      reg_req.rd_req = 1'b0;
      waited++;
    end while (!reg_resp.rd_resp && waited < RD_TIMEOUT);
    assert (reg_resp.rd_resp) else begin
      $display("Read at address %h got no response within %0d cycles", addr, RD_TIMEOUT);
      timeout_errors++;
    end
    check_equal("read latency", 2, waited);
    data = reg_resp.rd_data;
  endtask

  task automatic randomize_streams();
    for (int i = 0; i < LANES; i++) begin
      v2e[i].tdata    = {$random(seed), $random(seed)};
      v2e[i].tlast    = 1'($random(seed));
      mgt_rx[i].tdata = {$random(seed), $random(seed)};
      mgt_rx[i].tlast = 1'($random(seed));
    end
    v2e_valid    = 4'($random(seed));
    mgt_tx_ready = 4'($random(seed));
    mgt_rx_valid = 4'($random(seed));
    e2v_ready    = 4'($random(seed));
    mgt_link     = 4'($random(seed));
  endtask

  task automatic check_stream_outputs(input string test);
    for (int i = 0; i < LANES; i++) begin
      if (mode_m[i] == qsfp_port_pkg::AURORA) begin
        check_equal({test, " tx beat"}, v2e[i], mgt_tx[i]);
        check_equal({test, " tx valid"}, v2e_valid[i], mgt_tx_valid[i]);
        check_equal({test, " tx ready"}, mgt_tx_ready[i], v2e_ready[i]);
        check_equal({test, " rx beat"}, mgt_rx[i], e2v[i]);
        check_equal({test, " rx valid"}, mgt_rx_valid[i], e2v_valid[i]);
        check_equal({test, " rx ready"}, e2v_ready[i], mgt_rx_ready[i]);
        check_equal({test, " link up"}, mgt_link[i], link_up[i]);
      end else begin
        // Terminated lane sinks everything
        check_equal({test, " tx valid"}, 0, mgt_tx_valid[i]);
        check_equal({test, " rx valid"}, 0, e2v_valid[i]);
        check_equal({test, " tx ready"}, 1, v2e_ready[i]);
        check_equal({test, " rx ready"}, 1, mgt_rx_ready[i]);
        check_equal({test, " link up"}, 0, link_up[i]);
      end
      check_equal({test, " activity"}, act_hold_m[i] != 0, activity[i]);
    end
  endtask

  task automatic run_traffic(input int cycles, input string test);
    repeat (cycles) begin
      @(negedge bus_clk);
      randomize_streams();
      #1;
      check_stream_outputs(test);
    end
    @(negedge bus_clk);
    v2e_valid    = '0;
    mgt_rx_valid = '0;
  endtask

  task automatic check_lanes(input string test);
    qsfp_port_pkg::reg_data_t data;
    for (int i = 0; i < LANES; i++) begin
      reg_read(make_addr(i, 0, 0), data);
      check_equal({test, " mode"}, mode_m[i], data);
      reg_read(make_addr(i, 0, 2), data);
      check_equal({test, " tx beats"}, tx_beats_m[i], data);
      reg_read(make_addr(i, 0, 3), data);
      check_equal({test, " rx beats"}, rx_beats_m[i], data);
    end
  endtask

  //------------------------------------------------------------------------
  // Test sequence
  //------------------------------------------------------------------------
  initial begin
    qsfp_port_pkg::reg_data_t rd_data;
    qsfp_port_pkg::reg_addr_t addr;
    int                       lane;
    rst_i        = 1'b1;
    reg_req      = '0;
    v2e          = '0;
    v2e_valid    = '0;
    mgt_tx_ready = '0;
    mgt_rx       = '0;
    mgt_rx_valid = '0;
    e2v_ready    = '0;
    mgt_link     = '0;
    for (int i = 0; i < LANES; i++) mode_m[i] = qsfp_port_pkg::DISABLED;
    repeat (8) @(negedge bus_clk);
    rst_i = 1'b0;

    // Reset state, every lane disabled and idle
    run_traffic(4, "reset state");
    check_lanes("reset state");

    // Mode and port info registers
    repeat (24) begin
      lane = $random(seed) & 3;
      reg_write(make_addr(lane, 0, 0), $random(seed));
      reg_read(make_addr(lane, 0, 0), rd_data);
      check_equal("mode readback", mode_m[lane], rd_data);
      mgt_link = 4'($random(seed));
      reg_read(make_addr(lane, 0, 1), rd_data);
      check_equal("port info", port_info_exp(lane), rd_data);
      reg_write(make_addr(lane, 0, 1), $random(seed));
      reg_read(make_addr(lane, 0, 1), rd_data);
      check_equal("port info after write", port_info_exp(lane), rd_data);
    end

    // Passthrough on even lanes, termination on odd lanes, then swapped
    for (int i = 0; i < LANES; i++) reg_write(make_addr(i, 0, 0), (i % 2 == 0) ? 1 : 0);
    run_traffic(300, "traffic even");
    check_lanes("traffic even");
    for (int i = 0; i < LANES; i++) reg_write(make_addr(i, 0, 0), (i % 2 == 0) ? 0 : 1);
    run_traffic(300, "traffic odd");
    check_lanes("traffic odd");
    for (int i = 0; i < LANES; i++) reg_write(make_addr(i, 0, 0), $random(seed));
    run_traffic(200, "traffic random");
    check_lanes("traffic random");

    // Error hole in regions 1 and 2
    for (int i = 0; i < LANES; i++) begin
      for (int region = 1; region <= 2; region++) begin
        addr        = 16'($random(seed));
        addr[15:14] = 2'(i);
        addr[13:12] = 2'(region);
        reg_read(addr, rd_data);
        check_equal("error region read", `QSFP_ERR_DATA, rd_data);
        reg_write(addr, $random(seed));
      end
    end
    check_lanes("error region");

    $display("Errors: %0d value, %0d timeout, %0d assertion", value_errors, timeout_errors,
             u_dut.u_assertions.assert_errors);
    if (value_errors + timeout_errors + u_dut.u_assertions.assert_errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- qsfp_port.f
+incdir+design
design/qsfp_port_pkg.sv
design/qsfp_reg_decode.sv
design/qsfp_lane_regs.sv
design/qsfp_lane_datapath.sv
design/qsfp_port.sv
verif/qsfp_port_assertions.sv
verif/qsfp_port_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the QSFP port testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f qsfp_port.f --top-module qsfp_port_tb -o qsfp_port_sim

./obj_dir/qsfp_port_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  exit 1
fi
grep -q "ALL TESTS PASSED" sim.log
